// ==== hw/vendingPkg.sv ====
// Vending machine shared definitions
// coin and controller state encodings, width types and coin values
// all amounts are counted in nickel units

package vendingPkg;

    // coin code on the deposit input and the returned-coin output
    typedef enum logic [1:0] {
        NONE,
        NICKEL,
        DIME,
        QUARTER
    } coinT;

    // transaction controller states
    typedef enum logic [1:0] {
        ACCEPTING,
        CHANGE,
        REFUND,
        BEVERAGE
    } ctrlStateT;

    // money inside one transaction, in nickels
    typedef logic [3:0] nickelsT;

    // signed running balance, -16 to 15 nickels
    typedef logic signed [4:0] balanceT;

    // one item costs 25 cents
    localparam nickelsT PRICE_NICKELS = 4'd5;

    // nickel value of a coin code
    function automatic nickelsT coinValue(input coinT coin);
        case (coin)
            NICKEL:  return 4'd1;
            DIME:    return 4'd2;
            QUARTER: return 4'd5;
            default: return 4'd0;
        endcase
    endfunction

endpackage

// ==== hw/coinVault.sv ====
// Coin vault
// one saturating tube counter per denomination, counted since reset
// reports full tubes and whether a nickel can be paid out

module coinVault #(
    parameter int tubeBits = 3
) (
    input  logic clock,
    input  logic rstN,
    input  logic incNickel,
    input  logic incDime,
    input  logic incQuarter,
    input  logic decNickel,
    input  logic decDime,
    output logic nickelFull,
    output logic dimeFull,
    output logic quarterFull,
    output logic nickelAvail
);

    // tube index 0 nickel, 1 dime, 2 quarter
    logic [2:0] incVec;
    logic [2:0] decVec;
    logic [2:0] fullVec;
    logic [2:0] emptyVec;
    logic [tubeBits-1:0] tubeCount [3];

    assign incVec = {incQuarter, incDime, incNickel};
    // quarters are never paid out as change
    assign decVec = {1'b0, decDime, decNickel};

    for (genvar i = 0; i < 3; i++) begin : gTube
        // capacity is all ones
        assign fullVec[i]  = (tubeCount[i] == {tubeBits{1'b1}});
        assign emptyVec[i] = (tubeCount[i] == '0);

        always_ff @(posedge clock or negedge rstN) begin
            if (!rstN) begin
                tubeCount[i] <= '0;
            end else if (incVec[i] && !decVec[i] && !fullVec[i]) begin
                tubeCount[i] <= tubeCount[i] + 1'b1;
            end else if (decVec[i] && !incVec[i] && !emptyVec[i]) begin
                tubeCount[i] <= tubeCount[i] - 1'b1;
            end
        end

        // the controller must respect the full flag before storing a coin
        assert property (@(posedge clock) disable iff (!rstN)
            incVec[i] |-> !fullVec[i])
            else $error("coin stored into a full tube %0d", i);

        // change is only paid from coins that are really in the tube
        assert property (@(posedge clock) disable iff (!rstN)
            decVec[i] |-> !emptyVec[i])
            else $error("coin taken from an empty tube %0d", i);
    end

    assign nickelFull  = fullVec[0];
    assign dimeFull    = fullVec[1];
    assign quarterFull = fullVec[2];
    assign nickelAvail = !emptyVec[0];

endmodule

// ==== hw/vendController.sv ====
// Vending transaction controller
// takes coins until 25 cents, pays change one coin per cycle,
// then pulses beverage; refunds three dimes when no nickel is left

module vendController (
    input  logic               clock,
    input  logic               rstN,
    input  vendingPkg::coinT   deposit,
    input  logic               nickelFull,
    input  logic               dimeFull,
    input  logic               quarterFull,
    input  logic               nickelAvail,
    output logic               incNickel,
    output logic               incDime,
    output logic               incQuarter,
    output logic               decNickel,
    output logic               decDime,
    output vendingPkg::coinT   change,
    output logic               beverage,
    output logic               enable
);

    import vendingPkg::*;

    ctrlStateT state;
    ctrlStateT stateNext;
    coinT      changeNext;

    // coins taken in the current transaction
    logic [2:0] nickelCount;
    logic [1:0] dimeCount;
    logic       quarterCount;
    logic [2:0] nickelNext;
    logic [1:0] dimeNext;
    logic       quarterNext;

    // transaction total in nickels
    nickelsT total;

    assign total = nickelsT'(nickelCount) + nickelsT'({dimeCount, 1'b0})
                 + (quarterCount ? coinValue(QUARTER) : nickelsT'(0));

    // coins only while idle and still short of the price
    assign enable   = (state == ACCEPTING) && (total < PRICE_NICKELS);
    assign beverage = (state == BEVERAGE);

    always_comb begin
        stateNext   = state;
        changeNext  = NONE;
        nickelNext  = nickelCount;
        dimeNext    = dimeCount;
        quarterNext = quarterCount;
        incNickel   = 1'b0;
        incDime     = 1'b0;
        incQuarter  = 1'b0;
        decNickel   = 1'b0;
        decDime     = 1'b0;

        case (state)
            ACCEPTING: begin
                if (!enable) begin
                    // price reached, deposits are ignored from here on
                    stateNext = CHANGE;
                end else begin
                    case (deposit)
                        NICKEL: begin
                            if (nickelFull) begin
                                changeNext = NICKEL;
                            end else begin
                                incNickel  = 1'b1;
                                nickelNext = nickelCount + 1'b1;
                            end
                        end
                        DIME: begin
                            if (dimeFull) begin
                                changeNext = DIME;
                            end else begin
                                incDime  = 1'b1;
                                dimeNext = dimeCount + 1'b1;
                            end
                        end
                        QUARTER: begin
                            if (quarterFull) begin
                                changeNext = QUARTER;
                            end else begin
                                incQuarter  = 1'b1;
                                quarterNext = 1'b1;
                            end
                        end
                        default: begin
                            changeNext = NONE;
                        end
                    endcase
                end
            end
            // total is between 25 and 45 cents on entry
            CHANGE: begin
                if (total == PRICE_NICKELS) begin
                    stateNext = BEVERAGE;
                end else if (total == PRICE_NICKELS + 1'b1) begin
                    // 30 cents needs one nickel back
                    if (nickelAvail) begin
                        changeNext = NICKEL;
                        decNickel  = 1'b1;
                        stateNext  = BEVERAGE;
                    end else begin
                        stateNext = REFUND;
                    end
                end else if (dimeCount != 2'd0) begin
                    // 35 cents or more, dimes of this transaction go first
                    changeNext = DIME;
                    decDime    = 1'b1;
                    dimeNext   = dimeCount - 1'b1;
                end else begin
                    // a quarter and nickels, those nickels are in the tube
                    changeNext = NICKEL;
                    decNickel  = 1'b1;
                    nickelNext = nickelCount - 1'b1;
                end
            end
            // hand back the deposited dimes one by one
            REFUND: begin
                if (dimeCount != 2'd0) begin
                    changeNext = DIME;
                    decDime    = 1'b1;
                    dimeNext   = dimeCount - 1'b1;
                end else begin
                    nickelNext  = '0;
                    quarterNext = 1'b0;
                    stateNext   = ACCEPTING;
                end
            end
            // single dispense cycle, transaction starts over
            BEVERAGE: begin
                nickelNext  = '0;
                dimeNext    = '0;
                quarterNext = 1'b0;
                stateNext   = ACCEPTING;
            end
            default: begin
                stateNext = ACCEPTING;
            end
        endcase
    end

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            state        <= ACCEPTING;
            change       <= NONE;
            nickelCount  <= '0;
            dimeCount    <= '0;
            quarterCount <= 1'b0;
        end else begin
            state        <= stateNext;
            change       <= changeNext;
            nickelCount  <= nickelNext;
            dimeCount    <= dimeNext;
            quarterCount <= quarterNext;
        end
    end

    // dispense is a one-cycle strobe
    assert property (@(posedge clock) disable iff (!rstN)
        beverage |=> !beverage)
        else $error("beverage held for two cycles");

    // quarters come back only as rejected deposits
    assert property (@(posedge clock) disable iff (!rstN)
        (state != ACCEPTING) |-> (change != QUARTER))
        else $error("quarter returned during change or refund");

    // coin intake reopens only once the transaction counts are cleared
    assert property (@(posedge clock) disable iff (!rstN)
        $rose(enable) |-> (total == '0))
        else $error("enable rose with coins of the last transaction still counted");

endmodule

// ==== hw/balanceMonitor.sv ====
// Balance monitor
// running money in minus change and goods out, in nickels
// reads zero whenever the machine sits idle between transactions

module balanceMonitor (
    input  logic                clock,
    input  logic                rstN,
    input  vendingPkg::coinT    deposit,
    input  vendingPkg::coinT    change,
    input  logic                beverage,
    output vendingPkg::balanceT balance
);

    import vendingPkg::*;

    balanceT valueIn;
    balanceT valueOut;

    // deposits count even when enable is low
    assign valueIn = balanceT'({1'b0, coinValue(deposit)});

    // a dispense takes the price out of the balance
    assign valueOut = balanceT'({1'b0, coinValue(change)})
                    + (beverage ? balanceT'({1'b0, PRICE_NICKELS}) : balanceT'(0));

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            balance <= '0;
        end else begin
            balance <= balance + valueIn - valueOut;
        end
    end

    // the machine never pays out more than it was given
    assert property (@(posedge clock) disable iff (!rstN)
        balance >= 0)
        else $error("balance went negative: %0d", balance);

endmodule

// ==== hw/vendingTop.sv ====
// Vending machine top level
// transaction controller, coin vault and balance monitor

module vendingTop #(
    parameter int tubeBits = 3
) (
    input  logic                clock,
    input  logic                rstN,
    input  vendingPkg::coinT    deposit,
    output vendingPkg::coinT    change,
    output logic                beverage,
    output logic                enable,
    output vendingPkg::balanceT balance
);

    // vault strobes and flags
    logic incNickel;
    logic incDime;
    logic incQuarter;
    logic decNickel;
    logic decDime;
    logic nickelFull;
    logic dimeFull;
    logic quarterFull;
    logic nickelAvail;

    vendController uController (
        .clock       (clock),
        .rstN        (rstN),
        .deposit     (deposit),
        .nickelFull  (nickelFull),
        .dimeFull    (dimeFull),
        .quarterFull (quarterFull),
        .nickelAvail (nickelAvail),
        .incNickel   (incNickel),
        .incDime     (incDime),
        .incQuarter  (incQuarter),
        .decNickel   (decNickel),
        .decDime     (decDime),
        .change      (change),
        .beverage    (beverage),
        .enable      (enable)
    );

    coinVault #(
        .tubeBits (tubeBits)
    ) uVault (
        .clock       (clock),
        .rstN        (rstN),
        .incNickel   (incNickel),
        .incDime     (incDime),
        .incQuarter  (incQuarter),
        .decNickel   (decNickel),
        .decDime     (decDime),
        .nickelFull  (nickelFull),
        .dimeFull    (dimeFull),
        .quarterFull (quarterFull),
        .nickelAvail (nickelAvail)
    );

    // watches the external coin traffic only
    balanceMonitor uMonitor (
        .clock    (clock),
        .rstN     (rstN),
        .deposit  (deposit),
        .change   (change),
        .beverage (beverage),
        .balance  (balance)
    );

endmodule

// ==== tb/tbChecker.sv ====
// Vending machine checker
// watches change, beverage, enable and balance of the DUT and compares each
// test against the returned total, dispense count and balance from the file

module tbChecker (
    input logic                clock,
    input logic                rstN,
    input vendingPkg::coinT    change,
    input logic                beverage,
    input logic                enable,
    input vendingPkg::balanceT balance
);

    import vendingPkg::*;

    // running totals since reset, written only by the sampling block
    int totalReturned  = 0;
    int totalBeverages = 0;
    int enableErrors   = 0;

    // snapshot taken when a test starts
    int baseReturned     = 0;
    int baseBeverages    = 0;
    int baseEnableErrors = 0;
    logic [127:0] currentName = '0;

    // result counters, read by the testbench top
    int testCount  = 0;
    int passCount  = 0;
    int failCount  = 0;
    int errorCount = 0;

    // value of a returned coin in nickels
    function automatic int coinNickels(input coinT coin);
        case (coin)
            NICKEL:  return 1;
            DIME:    return 2;
            QUARTER: return 5;
            default: return 0;
        endcase
    endfunction

    // change and beverage each hold for one full cycle, so one negedge sees them
    always @(negedge clock) begin
        if (rstN) begin
            totalReturned <= totalReturned + coinNickels(change);
            if (beverage) begin
                totalBeverages <= totalBeverages + 1;
            end
            // coins stay locked out until the dispense is over
            if (beverage && enable) begin
                $display("enable was high during the dispense pulse in %0s",
                         currentName);
                enableErrors <= enableErrors + 1;
            end
        end
    end

    task automatic startTest(input logic [127:0] name);
        currentName      = name;
        baseReturned     = totalReturned;
        baseBeverages    = totalBeverages;
        baseEnableErrors = enableErrors;
    endtask

    task automatic finishTest(input int expReturned, input int expDispensed,
                              input int expBalance);
        int  gotReturned;
        int  gotDispensed;
        int  gotBalance;
        bit  testOk;
        gotReturned  = totalReturned - baseReturned;
        gotDispensed = totalBeverages - baseBeverages;
        gotBalance   = int'(balance);
        testOk       = 1'b1;
        if (gotReturned != expReturned) begin
            $display("Mismatch in %0s returned total: expected %0d, actual %0d",
                     currentName, expReturned, gotReturned);
            testOk = 1'b0;
            errorCount++;
        end
        if (gotDispensed != expDispensed) begin
            $display("Mismatch in %0s dispense count: expected %0d, actual %0d",
                     currentName, expDispensed, gotDispensed);
            testOk = 1'b0;
            errorCount++;
        end
        if (gotBalance != expBalance) begin
            $display("Mismatch in %0s balance: expected %0d, actual %0d",
                     currentName, expBalance, gotBalance);
            testOk = 1'b0;
            errorCount++;
        end
        if (enableErrors != baseEnableErrors) begin
            testOk = 1'b0;
        end
        testCount++;
        if (testOk) begin
            passCount++;
            $display("test %0s passed", currentName);
        end else begin
            failCount++;
            $display("test %0s FAILED", currentName);
        end
    endtask

endmodule

// ==== tb/tbVending.sv ====
// Vending machine testbench
// reads the tests from the stimulus file and drives coins into the DUT,
// the checker beside it does the comparing

module tbVending;

    import vendingPkg::*;

    localparam int tubeBits      = 3;
    localparam int resetCycles   = 10;
    localparam int cyclesPerTest = 40;
    localparam int maxTests      = 32;
    localparam int lineBytes     = 100;
    localparam int fieldBytes    = 16;

    logic    clock;
    logic    rstN;
    coinT    deposit;
    coinT    change;
    logic    beverage;
    logic    enable;
    balanceT balance;

    // test table loaded from the file
    logic [8*fieldBytes-1:0] testName  [maxTests];
    logic [8*fieldBytes-1:0] testCoins [maxTests];
    int expReturned  [maxTests];
    int expDispensed [maxTests];
    int expBalance   [maxTests];
    int numTests   = 0;
    int fileErrors = 0;
    int failures   = 0;
    bit loaded     = 1'b0;

    vendingTop #(
        .tubeBits (tubeBits)
    ) uut (
        .clock    (clock),
        .rstN     (rstN),
        .deposit  (deposit),
        .change   (change),
        .beverage (beverage),
        .enable   (enable),
        .balance  (balance)
    );

    tbChecker uChecker (
        .clock    (clock),
        .rstN     (rstN),
        .change   (change),
        .beverage (beverage),
        .enable   (enable),
        .balance  (balance)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // first printable byte of a line read by $fgets
    function automatic logic [7:0] leadingChar(input logic [8*lineBytes-1:0] line);
        logic [7:0] ch;
        ch = 8'h00;
        for (int k = lineBytes - 1; k >= 0; k--) begin
            if (ch == 8'h00) begin
                ch = line[k*8 +: 8];
            end
        end
        return ch;
    endfunction

    // N, D and Q in the coin column
    function automatic coinT charToCoin(input logic [7:0] ch);
        case (ch)
            "N":     return NICKEL;
            "D":     return DIME;
            "Q":     return QUARTER;
            default: return NONE;
        endcase
    endfunction

    task automatic loadTests();
        int fd;
        int code;
        int retVal;
        int bevVal;
        int balVal;
        logic [8*lineBytes-1:0]  lineBuf;
        logic [8*fieldBytes-1:0] nameBuf;
        logic [8*fieldBytes-1:0] coinBuf;
        fd = $fopen("tb/vending_stimulus.txt", "r");
        if (fd == 0) begin
            $display("cannot open the stimulus file tb/vending_stimulus.txt");
        end else begin
            lineBuf = '0;
            while ($fgets(lineBuf, fd) != 0) begin
                code    = 0;
                nameBuf = '0;
                coinBuf = '0;
                // lines starting with # only describe the columns
                if (leadingChar(lineBuf) != "#") begin
                    code = $sscanf(lineBuf, "%s %s %d %d %d",
                                   nameBuf, coinBuf, retVal, bevVal, balVal);
                end
                if (code == 5 && numTests < maxTests) begin
                    testName[numTests]     = nameBuf;
                    testCoins[numTests]    = coinBuf;
                    expReturned[numTests]  = retVal;
                    expDispensed[numTests] = bevVal;
                    expBalance[numTests]   = balVal;
                    numTests++;
                end
                lineBuf = '0;
            end
            $fclose(fd);
        end
    endtask

    // enable is looked at on the falling edge, where it is settled
    task automatic waitForEnable();
        @(negedge clock);
        while (!enable) begin
            @(negedge clock);
        end
    endtask

    // one coin for exactly one cycle, then back to NONE
    task automatic driveCoin(input logic [7:0] ch);
        coinT coin;
        coin = charToCoin(ch);
        if (coin == NONE) begin
            $display("unknown coin character %c in the stimulus file", ch);
            fileErrors++;
        end else begin
            waitForEnable();
            @(posedge clock);
            deposit <= coin;
            @(posedge clock);
            deposit <= NONE;
        end
    endtask

    // transaction over once enable stays high for two cycles
    task automatic waitForIdle();
        int highCycles;
        highCycles = 0;
        while (highCycles < 2) begin
            @(negedge clock);
            if (enable) begin
                highCycles++;
            end else begin
                highCycles = 0;
            end
        end
    endtask

    task automatic runTest(input int t);
        logic [7:0] ch;
        uChecker.startTest(testName[t]);
        // first coin sits in the highest used byte
        for (int k = fieldBytes - 1; k >= 0; k--) begin
            ch = testCoins[t][k*8 +: 8];
            if (ch != 8'h00) begin
                driveCoin(ch);
            end
        end
        waitForIdle();
        uChecker.finishTest(expReturned[t], expDispensed[t], expBalance[t]);
    endtask

    // watchdog, sized from the number of tests in the file
    initial begin
        wait (loaded);
        repeat (resetCycles + numTests * cyclesPerTest) @(posedge clock);
        $display("run timed out after %0d cycles, a test never finished",
                 resetCycles + numTests * cyclesPerTest);
        $display("Errors found");
        $finish;
    end

    initial begin
        rstN    = 1'b0;
        deposit = NONE;
        loadTests();
        if (numTests == 0) begin
            $display("no test could be read from the stimulus file");
            $display("Errors found");
            $finish;
        end else begin
            loaded = 1'b1;
            repeat (resetCycles) @(posedge clock);
            rstN <= 1'b1;
            @(negedge clock);
            for (int t = 0; t < numTests; t++) begin
                runTest(t);
            end
            failures = uChecker.failCount + fileErrors;
            $display("tests %0d, passed %0d, failed %0d, mismatches %0d",
                     uChecker.testCount, uChecker.passCount,
                     uChecker.failCount, uChecker.errorCount);
            if (failures == 0) begin
                $display("No errors");
            end else begin
                $display("Errors found");
            end
            $finish;
        end
    end

endmodule

// ==== tb/vending_stimulus.txt ====
# columns: name coins returned_nickels dispense_count final_balance
# coins are N, D, Q in deposit order, tubes carry over from test to test
#
# nickel tube still empty, thirty cents in dimes is refunded
refundDimes     DDD     6 0 0
#
# exact payment
exactQuarter    Q       0 1 0
dimeDimeNickel  DDN     0 1 0
#
# thirty cents again, the stored nickel goes back as change
dimesNickelBack DDD     1 1 0
fiveNickels     NNNNN   0 1 0
#
# overpayment, dimes of the transaction are paid back first
dimeDimeQuarter DDQ     4 1 0
dimeQuarter     DQ      2 1 0
nickelsQuarter  NNQ     2 1 0
nickelQuarter   NQ      1 1 0
#
# fill the quarter tube up to seven
quarterSix      Q       0 1 0
quarterSeven    Q       0 1 0
#
# eighth quarter comes straight back
quarterFull     Q       5 0 0
#
# machine still sells after the rejected coin
dimeDimeNickel2 DDN     0 1 0

// ==== filelist.f ====
hw/vendingPkg.sv
hw/coinVault.sv
hw/vendController.sv
hw/balanceMonitor.sv
hw/vendingTop.sv
tb/tbChecker.sv
tb/tbVending.sv

// ==== Makefile ====
# Verilator build and run of the vending machine testbench
# every variable below can be set on the command line

VERILATOR ?= verilator
TOP       ?= tbVending
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
FAIL_MSG  ?= Errors found
PASS_MSG  ?= No errors

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation reported failures, see $(LOG)"; exit 1; \
	elif grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
